//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      = exe_tb
FILELIST = all.f

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

//--- all.f
source/exe_pkg.sv
source/exe_issue_latch.sv
source/exe_alu.sv
source/exe_branch_store.sv
source/exe_retire_reg.sv
source/exe_top.sv
dv/exe_checker.sv
dv/exe_monitor.sv
dv/exe_tb.sv

//--- dv/exe_checker.sv
/*
 * concurrent checks on the result strobe, its latency and the
 * reset state of the execute stage, bound to exe_top
 */
`timescale 1ns/10ps

module exe_checker (
	input logic                 clk_i,
	input logic                 rst_n_i,
	input logic                 issue_valid_i,
	input logic                 result_valid_i,
	input exe_pkg::exe_result_t result_i
);

	// no strobe and no store enable while reset is held
	assert property (@(posedge clk_i) !rst_n_i |-> (!result_valid_i && !result_i.mem_wen))
		else $error("result strobe or store enable active during reset");

	// fixed two-cycle latency, both directions
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		result_valid_i |-> $past(issue_valid_i, 2))
		else $error("result strobe without an issue two cycles earlier");

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$past(issue_valid_i, 2) |-> result_valid_i)
		else $error("issue not retired two cycles later");

	// store enable only together with a result strobe
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!result_valid_i |-> !result_i.mem_wen)
		else $error("store enable high without a result strobe");

endmodule

bind exe_top exe_checker u_checker (
	.clk_i          (clk_i),
	.rst_n_i        (rst_n_i),
	.issue_valid_i  (issue_valid_i),
	.result_valid_i (result_valid_o),
	.result_i       (result_o)
);

//--- dv/exe_monitor.sv
/*
 * result monitor, queues expected bundles and compares each
 * retired bundle field by field
 */
`timescale 1ns/10ps

module exe_monitor (
	input logic                 clk_i,
	input logic                 rst_n_i,
	input logic                 result_valid_i,
	input exe_pkg::exe_result_t result_i
);
	import exe_pkg::*;

	exe_result_t want_q[$];
	string       name_q[$];
	exe_result_t want;
	string       test;
	bit          ok;
	int          outstanding = 0;
	int          pass_count = 0;
	int          fail_count = 0;
	int          stray_count = 0;

	task automatic expect_result(input exe_result_t exp_bundle, input string name);
		want_q.push_back(exp_bundle);
		name_q.push_back(name);
		outstanding = want_q.size();
	endtask

	function automatic bit field_ok(input string name, input string field,
			input logic [31:0] got, input logic [31:0] exp_val);
		if (got !== exp_val) begin
			$display("[ERROR] %0t: %s field %s got %h expected %h",
				$time, name, field, got, exp_val);
			return 1'b0;
		end
		return 1'b1;
	endfunction

	// outputs settle after the rising edge, sample on the falling one
	always @(negedge clk_i) begin
		if (rst_n_i && result_valid_i) begin
			if (want_q.size() == 0) begin
				$display("unexpected result strobe at %0t with nothing outstanding", $time);
				stray_count++;
			end else begin
				want = want_q.pop_front();
				test = name_q.pop_front();
				outstanding = want_q.size();
				ok = 1'b1;
				ok &= field_ok(test, "alu_result", result_i.alu_result, want.alu_result);
				ok &= field_ok(test, "wb_en", 32'(result_i.wb_en), 32'(want.wb_en));
				ok &= field_ok(test, "rd", 32'(result_i.rd), 32'(want.rd));
				ok &= field_ok(test, "load_type", 32'(result_i.load_type), 32'(want.load_type));
				ok &= field_ok(test, "mem_wen", 32'(result_i.mem_wen), 32'(want.mem_wen));
				ok &= field_ok(test, "mem_wdata", result_i.mem_wdata, want.mem_wdata);
				ok &= field_ok(test, "branch_taken", 32'(result_i.branch_taken),
					32'(want.branch_taken));
				ok &= field_ok(test, "branch_target", result_i.branch_target,
					want.branch_target);
				if (ok) begin
					pass_count++;
					$display("PASS %s", test);
				end else begin
					fail_count++;
					$display("FAIL %s", test);
				end
			end
		end
	end

endmodule

//--- dv/exe_tb.sv
/*
 * execute stage testbench, clock and reset, stimulus table,
 * LFSR data, watchdog and final report
 */
`timescale 1ns/10ps

module exe_tb;
	import exe_pkg::*;

	localparam int clk_period   = 40;
	localparam int reset_cycles = 8;

	logic        clk;
	logic        rst_n;
	logic        issue_valid;
	exe_issue_t  issue_bus;
	logic        result_valid;
	exe_result_t result;

	exe_issue_t  issue_tab[$];
	exe_result_t want_tab[$];
	string       name_tab[$];
	int          gap_tab[$];
	int          num_rows = 0;
	logic [31:0] lfsr_state = 32'h84734f13;

	exe_top UUT (
		.clk_i          (clk),
		.rst_n_i        (rst_n),
		.issue_valid_i  (issue_valid),
		.issue_i        (issue_bus),
		.result_valid_o (result_valid),
		.result_o       (result)
	);

	exe_monitor u_monitor (
		.clk_i          (clk),
		.rst_n_i        (rst_n),
		.result_valid_i (result_valid),
		.result_i       (result)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic logic [31:0] next_pc();
		return 32'h0000_2000 + 32'(issue_tab.size()) * 32'd4;
	endfunction

	function automatic exe_issue_t make_issue(input alu_op_e op, input src1_sel_e s1,
			input src2_sel_e s2, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] imm);
		exe_issue_t iss;
		iss = '0;
		iss.pc = next_pc();
		iss.rs1_val = a;
		iss.rs2_val = b;
		iss.imm = imm;
		iss.alu_op = op;
		iss.src1_sel = s1;
		iss.src2_sel = s2;
		iss.wb_en = 1'b1;
		iss.rd = 5'(issue_tab.size() + 1);
		return iss;
	endfunction

	// expected store data, target and pass-through fields
	task automatic add_row(input string name, input exe_issue_t iss,
			input logic [31:0] exp_alu, input logic taken);
		exe_result_t exp_bundle;
		exp_bundle.alu_result = exp_alu;
		exp_bundle.wb_en = iss.wb_en;
		exp_bundle.rd = iss.rd;
		exp_bundle.load_type = iss.load_type;
		exp_bundle.mem_wen = (iss.store_type != ST_NONE);
		case (iss.store_type)
			ST_SB:   exp_bundle.mem_wdata = {24'h0, iss.rs2_val[7:0]};
			ST_SH:   exp_bundle.mem_wdata = {16'h0, iss.rs2_val[15:0]};
			ST_SW:   exp_bundle.mem_wdata = iss.rs2_val;
			default: exp_bundle.mem_wdata = '0;
		endcase
		exp_bundle.branch_taken = taken;
		exp_bundle.branch_target = iss.pc + iss.imm;
		issue_tab.push_back(iss);
		want_tab.push_back(exp_bundle);
		name_tab.push_back(name);
		// every fifth row leaves an idle gap, the rest go back to back
		gap_tab.push_back((issue_tab.size() % 5 == 0) ? 2 : 0);
	endtask

	task automatic alu_row(input string name, input alu_op_e op, input src1_sel_e s1,
			input src2_sel_e s2, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] exp_alu);
		logic [31:0] rs2;
		logic [31:0] imm;
		// the unselected operand two source holds the complement
		rs2 = (s2 == SRC2_IMM) ? ~b : b;
		imm = (s2 == SRC2_IMM) ? b : ~b;
		add_row(name, make_issue(op, s1, s2, a, rs2, imm), exp_alu, 1'b0);
	endtask

	task automatic br_row(input string name, input branch_type_e bt, input logic [31:0] a,
			input logic [31:0] b, input logic taken);
		exe_issue_t iss;
		iss = make_issue(ALU_ADD, SRC1_ZERO, SRC2_ZERO, a, b, taken ? 32'h100 : 32'hffff_ff80);
		iss.branch_type = bt;
		iss.wb_en = 1'b0;
		add_row(name, iss, 32'h0, taken);
	endtask

	task automatic st_row(input string name, input store_type_e st, input load_type_e lt);
		exe_issue_t  iss;
		logic [31:0] base;
		logic [31:0] data;
		logic [31:0] offset;
		base = lfsr_take(32);
		data = lfsr_take(32);
		offset = lfsr_take(12);
		iss = make_issue(ALU_ADD, SRC1_REG1, SRC2_IMM, base, data, offset);
		iss.store_type = st;
		iss.load_type = lt;
		iss.wb_en = (st == ST_NONE);
		add_row(name, iss, base + offset, 1'b0);
	endtask

	task automatic build_table();
		alu_row("add", ALU_ADD, SRC1_REG1, SRC2_REG2, 32'h1234, 32'hfff, 32'h2233);
		alu_row("sub", ALU_SUB, SRC1_REG1, SRC2_REG2, 32'h5, 32'h7, 32'hffff_fffe);
		alu_row("sll_imm", ALU_SLL, SRC1_REG1, SRC2_IMM, 32'hf1, 32'h24, 32'hf10);
		alu_row("slt_neg", ALU_SLT, SRC1_REG1, SRC2_REG2, 32'hffff_fffb, 32'h3, 32'h1);
		alu_row("slt_pos", ALU_SLT, SRC1_REG1, SRC2_REG2, 32'h3, 32'hffff_fffb, 32'h0);
		alu_row("sltu_big", ALU_SLTU, SRC1_REG1, SRC2_REG2, 32'hffff_fffb, 32'h3, 32'h0);
		alu_row("sltu_imm", ALU_SLTU, SRC1_REG1, SRC2_IMM, 32'h3, 32'hffff_fff0, 32'h1);
		alu_row("xor", ALU_XOR, SRC1_REG1, SRC2_REG2, 32'hff00_ff00, 32'h0ff0_0ff0,
			32'hf0f0_f0f0);
		alu_row("srl", ALU_SRL, SRC1_REG1, SRC2_REG2, 32'h8000_0010, 32'h4, 32'h0800_0001);
		alu_row("sra_neg", ALU_SRA, SRC1_REG1, SRC2_IMM, 32'h8000_0010, 32'h24, 32'hf800_0001);
		alu_row("sra_pos", ALU_SRA, SRC1_REG1, SRC2_REG2, 32'h7000_0000, 32'h1c, 32'h7);
		alu_row("or", ALU_OR, SRC1_REG1, SRC2_REG2, 32'h1200_0034, 32'h0056_7800,
			32'h1256_7834);
		alu_row("and_imm", ALU_AND, SRC1_REG1, SRC2_IMM, 32'h1234_5678, 32'hff0, 32'h670);
		alu_row("lui", ALU_PASS2, SRC1_ZERO, SRC2_IMM, 32'h5555_5555, 32'habcd_e000,
			32'habcd_e000);
		// operand selection, link address, upper immediate, pc relative
		alu_row("jal_link", ALU_ADD, SRC1_PC, SRC2_FOUR, 32'h5, 32'h9, next_pc() + 32'd4);
		alu_row("zero_imm", ALU_ADD, SRC1_ZERO, SRC2_IMM, 32'h7, 32'h1234_5000, 32'h1234_5000);
		alu_row("pc_imm", ALU_ADD, SRC1_PC, SRC2_IMM, 32'h7, 32'hffff_fff0, next_pc() - 32'd16);
		br_row("beq_taken", BR_BEQ, 32'hffff_fff9, 32'hffff_fff9, 1'b1);
		br_row("beq_not", BR_BEQ, 32'hffff_fff9, 32'h7, 1'b0);
		br_row("bne_taken", BR_BNE, 32'h1, 32'h2, 1'b1);
		br_row("bne_not", BR_BNE, 32'h9, 32'h9, 1'b0);
		br_row("blt_taken", BR_BLT, 32'hffff_fffd, 32'h2, 1'b1);
		br_row("blt_not", BR_BLT, 32'h2, 32'hffff_fffd, 1'b0);
		br_row("bge_taken", BR_BGE, 32'h2, 32'hffff_fffd, 1'b1);
		br_row("bge_not", BR_BGE, 32'hffff_fffd, 32'h2, 1'b0);
		br_row("bltu_taken", BR_BLTU, 32'h2, 32'hffff_fffd, 1'b1);
		br_row("bltu_not", BR_BLTU, 32'hffff_fffd, 32'h2, 1'b0);
		br_row("bgeu_taken", BR_BGEU, 32'hffff_fffd, 32'h2, 1'b1);
		br_row("bgeu_not", BR_BGEU, 32'h2, 32'hffff_fffd, 1'b0);
		br_row("br_none", BR_NONE, 32'h5, 32'h5, 1'b0);
		st_row("store_sb", ST_SB, LD_NONE);
		st_row("store_sh", ST_SH, LD_NONE);
		st_row("store_sw", ST_SW, LD_NONE);
		st_row("no_store_lhu", ST_NONE, LD_LHU);
	endtask

	initial begin
		rst_n = 1'b0;
		issue_valid = 1'b0;
		issue_bus = '0;
		build_table();
		num_rows = issue_tab.size();
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
		// idle after reset, the monitor flags any strobe here
		repeat (3) @(negedge clk);
		for (int i = 0; i < num_rows; i++) begin
			issue_valid = 1'b1;
			issue_bus = issue_tab[i];
			u_monitor.expect_result(want_tab[i], name_tab[i]);
			@(negedge clk);
			issue_valid = 1'b0;
			repeat (gap_tab[i]) @(negedge clk);
		end
		wait (u_monitor.outstanding == 0);
		repeat (3) @(negedge clk);
		$display("tests run %0d, passed %0d, failed %0d, stray strobes %0d", num_rows,
			u_monitor.pass_count, u_monitor.fail_count, u_monitor.stray_count);
		if (u_monitor.fail_count == 0 && u_monitor.stray_count == 0 &&
				u_monitor.pass_count == num_rows) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// watchdog, two cycles per row plus reset and some slack
	initial begin
		wait (num_rows > 0);
		#((num_rows * 2 + reset_cycles + 20) * clk_period);
		$display("timeout: results still outstanding at %0t", $time);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- source/exe_alu.sv
/*
 * ALU with operand selection and the RV32I integer operations,
 * compares share the subtractor
 */
`timescale 1ns/10ps

module exe_alu (
	input  exe_pkg::exe_issue_t       cur_issue_i,
	output logic [exe_pkg::xlen-1:0]  alu_result_o
);
	import exe_pkg::*;

	logic [xlen-1:0]    src1;
	logic [xlen-1:0]    src2;
	logic [xlen-1:0]    sum;
	logic [xlen-1:0]    diff;
	logic               carry;
	logic               overflow;
	logic               less_signed;
	logic               less_unsigned;
	logic [shamt_w-1:0] shamt;

	// operand one
	always_comb begin
		case (cur_issue_i.src1_sel)
			SRC1_REG1: src1 = cur_issue_i.rs1_val;
			SRC1_PC:   src1 = cur_issue_i.pc;
			default:   src1 = '0;
		endcase
	end

	// operand two
	always_comb begin
		case (cur_issue_i.src2_sel)
			SRC2_REG2: src2 = cur_issue_i.rs2_val;
			SRC2_IMM:  src2 = cur_issue_i.imm;
			SRC2_FOUR: src2 = link_offset;
			default:   src2 = '0;
		endcase
	end

	assign sum = src1 + src2;

	// src1 + ~src2 + 1, carry out set when src1 >= src2 unsigned
	assign {carry, diff} = {1'b0, src1} + {1'b0, ~src2} + {{xlen{1'b0}}, 1'b1};

	// signed overflow when operand signs differ and result sign flips
	assign overflow = (src1[xlen-1] ^ src2[xlen-1]) & (src1[xlen-1] ^ diff[xlen-1]);

	assign less_signed   = diff[xlen-1] ^ overflow;
	assign less_unsigned = ~carry;

	assign shamt = src2[shamt_w-1:0];

	always_comb begin
		case (cur_issue_i.alu_op)
			ALU_ADD: begin
				alu_result_o = sum;
			end
			ALU_SUB: begin
				alu_result_o = diff;
			end
			ALU_SLL: begin
				alu_result_o = src1 << shamt;
			end
			ALU_SLT: begin
				alu_result_o = {{(xlen-1){1'b0}}, less_signed};
			end
			ALU_SLTU: begin
				alu_result_o = {{(xlen-1){1'b0}}, less_unsigned};
			end
			ALU_XOR: begin
				alu_result_o = src1 ^ src2;
			end
			ALU_SRL: begin
				alu_result_o = src1 >> shamt;
			end
			ALU_SRA: begin
				// sign fill from bit 31
				alu_result_o = $unsigned($signed(src1) >>> shamt);
			end
			ALU_OR: begin
				alu_result_o = src1 | src2;
			end
			ALU_AND: begin
				alu_result_o = src1 & src2;
			end
			ALU_PASS2: begin
				// LUI forwards the immediate untouched
				alu_result_o = src2;
			end
			default: begin
				alu_result_o = '0;
			end
		endcase
	end

endmodule

//--- source/exe_branch_store.sv
/*
 * branch condition and target, store enable and store data
 * masked by access width
 */
`timescale 1ns/10ps

module exe_branch_store (
	input  exe_pkg::exe_issue_t      cur_issue_i,
	output logic                     branch_taken_o,
	output logic [exe_pkg::xlen-1:0] branch_target_o,
	output logic                     mem_wen_o,
	output logic [exe_pkg::xlen-1:0] mem_wdata_o
);
	import exe_pkg::*;

	logic            rs_equal;
	logic            rs_less;
	logic            rs_less_u;
	logic [xlen-1:0] wdata_mask;

	// compares straight on the register values, not the ALU operands
	assign rs_equal  = (cur_issue_i.rs1_val == cur_issue_i.rs2_val);
	assign rs_less   = ($signed(cur_issue_i.rs1_val) < $signed(cur_issue_i.rs2_val));
	assign rs_less_u = (cur_issue_i.rs1_val < cur_issue_i.rs2_val);

	always_comb begin
		case (cur_issue_i.branch_type)
			BR_BEQ:  branch_taken_o = rs_equal;
			BR_BNE:  branch_taken_o = ~rs_equal;
			BR_BLT:  branch_taken_o = rs_less;
			BR_BGE:  branch_taken_o = ~rs_less;
			BR_BLTU: branch_taken_o = rs_less_u;
			BR_BGEU: branch_taken_o = ~rs_less_u;
			default: branch_taken_o = 1'b0;
		endcase
	end

	assign branch_target_o = cur_issue_i.pc + cur_issue_i.imm;

	assign mem_wen_o = (cur_issue_i.store_type != ST_NONE);

	// no store leaves the data bus at zero
	always_comb begin
		case (cur_issue_i.store_type)
			ST_SB:   wdata_mask = sb_mask;
			ST_SH:   wdata_mask = sh_mask;
			ST_SW:   wdata_mask = sw_mask;
			default: wdata_mask = '0;
		endcase
	end

	assign mem_wdata_o = cur_issue_i.rs2_val & wdata_mask;

endmodule

//--- source/exe_issue_latch.sv
/*
 * issue latch, captures the decoded bundle on the issue strobe
 * and holds it until the next instruction arrives
 */
`timescale 1ns/10ps

module exe_issue_latch (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                issue_valid_i,
	input  exe_pkg::exe_issue_t issue_i,
	output logic                cur_valid_o,
	output exe_pkg::exe_issue_t cur_issue_o
);
	import exe_pkg::*;

	logic         valid_q;
	logic         wb_en_q;
	store_type_e  store_type_q;
	branch_type_e branch_type_q;
	exe_issue_t   issue_q;

	// strobe and side-effect fields
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q       <= 1'b0;
			wb_en_q       <= 1'b0;
			store_type_q  <= ST_NONE;
			branch_type_q <= BR_NONE;
		end else begin
			valid_q <= issue_valid_i;
			if (issue_valid_i) begin
				wb_en_q       <= issue_i.wb_en;
				store_type_q  <= issue_i.store_type;
				branch_type_q <= issue_i.branch_type;
			end
		end
	end

	// operand payload
	always_ff @(posedge clk_i) begin
		if (issue_valid_i) begin
			issue_q <= issue_i;
		end
	end

	always_comb begin
		cur_issue_o             = issue_q;
		cur_issue_o.wb_en       = wb_en_q;
		cur_issue_o.store_type  = store_type_q;
		cur_issue_o.branch_type = branch_type_q;
	end

	assign cur_valid_o = valid_q;

endmodule

//--- source/exe_pkg.sv
/*
 * width constants, field encodings and the issue and result
 * bundles shared by the execute stage
 */
package exe_pkg;

	// RV32I data and register index widths
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;

	// shift amount comes from the low bits of operand two
	localparam int shamt_w = 5;

	// store data masks by access width
	localparam logic [xlen-1:0] sb_mask = 32'h0000_00ff;
	localparam logic [xlen-1:0] sh_mask = 32'h0000_ffff;
	localparam logic [xlen-1:0] sw_mask = 32'hffff_ffff;

	// return address offset for jump and link
	localparam logic [xlen-1:0] link_offset = 32'd4;

	// funct3 in the low bits, bit 3 marks SUB and SRA
	typedef enum logic [3:0] {
		ALU_ADD   = 4'b0000,
		ALU_SLL   = 4'b0001,
		ALU_SLT   = 4'b0010,
		ALU_SLTU  = 4'b0011,
		ALU_XOR   = 4'b0100,
		ALU_SRL   = 4'b0101,
		ALU_OR    = 4'b0110,
		ALU_AND   = 4'b0111,
		ALU_SUB   = 4'b1000,
		ALU_SRA   = 4'b1101,
		ALU_PASS2 = 4'b1111
	} alu_op_e;

	typedef enum logic [1:0] {
		SRC1_ZERO = 2'd0,
		SRC1_REG1 = 2'd1,
		SRC1_PC   = 2'd2
	} src1_sel_e;

	typedef enum logic [1:0] {
		SRC2_ZERO = 2'd0,
		SRC2_REG2 = 2'd1,
		SRC2_IMM  = 2'd2,
		SRC2_FOUR = 2'd3
	} src2_sel_e;

	typedef enum logic [1:0] {
		ST_NONE = 2'd0,
		ST_SB   = 2'd1,
		ST_SH   = 2'd2,
		ST_SW   = 2'd3
	} store_type_e;

	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_LB   = 3'd1,
		LD_LH   = 3'd2,
		LD_LW   = 3'd3,
		LD_LBU  = 3'd4,
		LD_LHU  = 3'd5
	} load_type_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_BEQ  = 3'd1,
		BR_BNE  = 3'd2,
		BR_BLT  = 3'd3,
		BR_BGE  = 3'd4,
		BR_BLTU = 3'd5,
		BR_BGEU = 3'd6
	} branch_type_e;

	// decoded instruction as handed to execute, 150 bits
	typedef struct packed {
		logic [xlen-1:0]       pc;
		logic [xlen-1:0]       rs1_val;
		logic [xlen-1:0]       rs2_val;
		logic [xlen-1:0]       imm;
		alu_op_e               alu_op;
		src1_sel_e             src1_sel;
		src2_sel_e             src2_sel;
		logic                  wb_en;
		logic [reg_addr_w-1:0] rd;
		store_type_e           store_type;
		load_type_e            load_type;
		branch_type_e          branch_type;
	} exe_issue_t;

	// retired bundle towards memory and writeback, 107 bits
	typedef struct packed {
		logic [xlen-1:0]       alu_result;
		logic                  wb_en;
		logic [reg_addr_w-1:0] rd;
		load_type_e            load_type;
		logic                  mem_wen;
		logic [xlen-1:0]       mem_wdata;
		logic                  branch_taken;
		logic [xlen-1:0]       branch_target;
	} exe_result_t;

endpackage

//--- source/exe_retire_reg.sv
/*
 * retire register, assembles the result bundle and presents it
 * with a one-cycle result strobe
 */
`timescale 1ns/10ps

module exe_retire_reg (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     cur_valid_i,
	input  exe_pkg::exe_issue_t      cur_issue_i,
	input  logic [exe_pkg::xlen-1:0] alu_result_i,
	input  logic                     branch_taken_i,
	input  logic [exe_pkg::xlen-1:0] branch_target_i,
	input  logic                     mem_wen_i,
	input  logic [exe_pkg::xlen-1:0] mem_wdata_i,
	output logic                     result_valid_o,
	output exe_pkg::exe_result_t     result_o
);
	import exe_pkg::*;

	exe_result_t result_d;
	exe_result_t result_q;
	logic        valid_q;
	logic        wb_en_q;
	logic        mem_wen_q;
	logic        branch_taken_q;

	always_comb begin
		result_d.alu_result    = alu_result_i;
		result_d.wb_en         = cur_issue_i.wb_en;
		result_d.rd            = cur_issue_i.rd;
		result_d.load_type     = cur_issue_i.load_type;
		result_d.mem_wen       = mem_wen_i;
		result_d.mem_wdata     = mem_wdata_i;
		result_d.branch_taken  = branch_taken_i;
		result_d.branch_target = branch_target_i;
	end

	// strobe and control fields
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q        <= 1'b0;
			wb_en_q        <= 1'b0;
			mem_wen_q      <= 1'b0;
			branch_taken_q <= 1'b0;
		end else begin
			valid_q <= cur_valid_i;
			if (cur_valid_i) begin
				wb_en_q        <= result_d.wb_en;
				mem_wen_q      <= result_d.mem_wen;
				branch_taken_q <= result_d.branch_taken;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (cur_valid_i) begin
			result_q <= result_d;
		end
	end

	always_comb begin
		result_o              = result_q;
		result_o.wb_en        = wb_en_q;
		result_o.mem_wen      = mem_wen_q;
		result_o.branch_taken = branch_taken_q;
	end

	assign result_valid_o = valid_q;

endmodule

//--- source/exe_top.sv
/*
 * execute stage top, issue latch, ALU, branch and store unit
 * and retire register
 */
`timescale 1ns/10ps

module exe_top (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 issue_valid_i,
	input  exe_pkg::exe_issue_t  issue_i,
	output logic                 result_valid_o,
	output exe_pkg::exe_result_t result_o
);
	import exe_pkg::*;

	logic            cur_valid;
	exe_issue_t      cur_issue;
	logic [xlen-1:0] alu_result;
	logic            branch_taken;
	logic [xlen-1:0] branch_target;
	logic            mem_wen;
	logic [xlen-1:0] mem_wdata;

	exe_issue_latch u_issue_latch (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.issue_valid_i (issue_valid_i),
		.issue_i       (issue_i),
		.cur_valid_o   (cur_valid),
		.cur_issue_o   (cur_issue)
	);

	exe_alu u_alu (
		.cur_issue_i  (cur_issue),
		.alu_result_o (alu_result)
	);

	exe_branch_store u_branch_store (
		.cur_issue_i     (cur_issue),
		.branch_taken_o  (branch_taken),
		.branch_target_o (branch_target),
		.mem_wen_o       (mem_wen),
		.mem_wdata_o     (mem_wdata)
	);

	exe_retire_reg u_retire_reg (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.cur_valid_i     (cur_valid),
		.cur_issue_i     (cur_issue),
		.alu_result_i    (alu_result),
		.branch_taken_i  (branch_taken),
		.branch_target_i (branch_target),
		.mem_wen_i       (mem_wen),
		.mem_wdata_i     (mem_wdata),
		.result_valid_o  (result_valid_o),
		.result_o        (result_o)
	);

endmodule
